/* Bender.yml */
package:
  name: cgra_conf

sources:
  - logic/cgra_pkg.sv
  - logic/hs_slice.sv
  - logic/cgra_conf_ctrl.sv
  - logic/cgra_pe.sv
  - logic/cgra_result_merge.sv
  - logic/cgra_conf_top.sv
  - target: test
    files:
      - tests/cgra_conf_props.sv
      - tests/cgra_conf_tb.sv

/* cgra_conf_top.f */
logic/cgra_pkg.sv
logic/hs_slice.sv
logic/cgra_conf_ctrl.sv
logic/cgra_pe.sv
logic/cgra_result_merge.sv
logic/cgra_conf_top.sv
tests/cgra_conf_props.sv
tests/cgra_conf_tb.sv

/* logic/cgra_conf_ctrl.sv */
`timescale 1ns/1ps

module cgra_conf_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  output logic                   line_req,
  input  logic                   line_ack,
  input  cgra_pkg::line_t        line_data,
  output logic                   conf_valid,
  output cgra_pkg::conf_word_t   conf_word,
  output cgra_pkg::lane_mask_t   in_mask,
  output cgra_pkg::lane_mask_t   out_mask,
  output logic                   done
);

  localparam int SLOT_W = $clog2(cgra_pkg::WORDS_PER_LINE);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HDR_FETCH,
    S_HDR_DECODE,
    S_SEND,
    S_LINE_FETCH,
    S_DONE
  } state_e;

  state_e                           state;
  cgra_pkg::line_t                  line_q;
  logic [cgra_pkg::HDR_CNT_W-1:0]   word_cnt;
  logic [cgra_pkg::HDR_CNT_W-1:0]   sent_cnt;
  logic [SLOT_W-1:0]                slot;

  // ******************************
  // Sequencer
  // ******************************
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      line_req   <= 1'b0;
      conf_valid <= 1'b0;
      done       <= 1'b0;
      in_mask    <= '0;
      out_mask   <= '0;
      word_cnt   <= '0;
      sent_cnt   <= '0;
      slot       <= '0;
    end else begin
      conf_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            line_req <= 1'b1;
            state    <= S_HDR_FETCH;
          end
        end
        S_HDR_FETCH: begin
          if (line_req && line_ack) begin
            line_req <= 1'b0;
            state    <= S_HDR_DECODE;
          end
        end
        S_HDR_DECODE: begin
          word_cnt <= line_q[cgra_pkg::HDR_CNT_LSB +: cgra_pkg::HDR_CNT_W];
          in_mask  <= line_q[cgra_pkg::HDR_IN_MASK_LSB +: cgra_pkg::N_PE];
          out_mask <= line_q[cgra_pkg::HDR_OUT_MASK_LSB +: cgra_pkg::N_PE];
          sent_cnt <= '0;
          slot     <= '0;
          if (line_q[cgra_pkg::HDR_CNT_LSB +: cgra_pkg::HDR_CNT_W] == '0) begin
            state <= S_DONE;                     // Empty configuration
          end else begin
            state <= S_LINE_FETCH;
          end
        end
        S_LINE_FETCH: begin
          // New req only once the previous ack has fallen
          if (!line_req && !line_ack) begin
            line_req <= 1'b1;
          end else if (line_req && line_ack) begin
            line_req <= 1'b0;
            state    <= S_SEND;
          end
        end
        S_SEND: begin
          conf_valid <= 1'b1;
          sent_cnt   <= sent_cnt + 1'b1;
          slot       <= slot + 1'b1;
          if (sent_cnt + 1'b1 == word_cnt) begin
            state <= S_DONE;
          end else if (slot == SLOT_W'(cgra_pkg::WORDS_PER_LINE - 1)) begin
            state <= S_LINE_FETCH;               // Line used up
          end
        end
        S_DONE: begin
          done <= 1'b1;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // ******************************
  // Line buffer and word output
  // ******************************
  always_ff @(posedge clk) begin
    if ((state == S_HDR_FETCH || state == S_LINE_FETCH) && line_req && line_ack) begin
      line_q <= line_data;                       // Sampled with ack high
    end else if (state == S_SEND) begin
      line_q    <= line_q >> cgra_pkg::CONF_W;
      conf_word <= line_q[cgra_pkg::CONF_W-1:0];  // Least significant first
    end
  end

endmodule

/* logic/cgra_conf_top.sv */
`timescale 1ns/1ps

module cgra_conf_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  output logic              done,
  output logic              line_req,
  input  logic              line_ack,
  input  cgra_pkg::line_t   line_data,
  input  logic              op_req,
  input  cgra_pkg::data_t   op_data,
  output logic              op_ack,
  output logic              res_req,
  output cgra_pkg::result_t res_data,
  input  logic              res_ack
);

  logic                 conf_valid;
  cgra_pkg::conf_word_t conf_word;
  cgra_pkg::lane_mask_t in_mask;
  cgra_pkg::lane_mask_t out_mask;
  logic                 op_valid;
  cgra_pkg::data_t      op_bus;
  cgra_pkg::lane_mask_t lane_valid;
  cgra_pkg::data_t      lane_data [cgra_pkg::N_PE];
  logic                 merge_ready;
  logic                 res_valid;
  cgra_pkg::result_t    merged;
  logic                 res_done;

  cgra_conf_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .line_req   (line_req),
    .line_ack   (line_ack),
    .line_data  (line_data),
    .conf_valid (conf_valid),
    .conf_word  (conf_word),
    .in_mask    (in_mask),
    .out_mask   (out_mask),
    .done       (done)
  );

  // Operands held off until configured and result port free
  hs_slice #(
    .payload_t (cgra_pkg::data_t),
    .is_sender (1'b0)
  ) u_op_slice (
    .clk       (clk),
    .rst       (rst),
    .in_req    (op_req),
    .in_data   (op_data),
    .in_ack    (op_ack),
    .enable    (done && merge_ready),
    .out_valid (op_valid),
    .out_data  (op_bus),
    .in_valid  (1'b0),
    .out_req   (),
    .out_ack   (1'b0)
  );

  for (genvar i = 0; i < cgra_pkg::N_PE; i++) begin : g_pe
    cgra_pe #(
      .pe_index (i)
    ) u_pe (
      .clk        (clk),
      .rst        (rst),
      .conf_valid (conf_valid),
      .conf_word  (conf_word),
      .in_en      (in_mask[i]),
      .op_valid   (op_valid),
      .op_data    (op_bus),
      .lane_valid (lane_valid[i]),
      .lane_data  (lane_data[i])
    );
  end

  cgra_result_merge u_merge (
    .clk        (clk),
    .rst        (rst),
    .lane_valid (lane_valid),
    .lane_data  (lane_data),
    .out_mask   (out_mask),
    .res_done   (res_done),
    .ready      (merge_ready),
    .res_valid  (res_valid),
    .res_data   (merged)
  );

  hs_slice #(
    .payload_t (cgra_pkg::result_t),
    .is_sender (1'b1)
  ) u_res_slice (
    .clk       (clk),
    .rst       (rst),
    .in_req    (1'b0),
    .in_data   (merged),
    .in_ack    (),
    .enable    (1'b1),
    .out_valid (res_done),                     // Pulses when ack falls
    .out_data  (res_data),
    .in_valid  (res_valid),
    .out_req   (res_req),
    .out_ack   (res_ack)
  );

endmodule

/* logic/cgra_pe.sv */
`timescale 1ns/1ps

module cgra_pe #(
  parameter int pe_index = 0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 conf_valid,
  input  cgra_pkg::conf_word_t conf_word,
  input  logic                 in_en,
  input  logic                 op_valid,
  input  cgra_pkg::data_t      op_data,
  output logic                 lane_valid,
  output cgra_pkg::data_t      lane_data
);

  logic [3:0]      op_q;
  cgra_pkg::data_t imm_q;
  cgra_pkg::data_t alu;

  // Configuration register, last matching word wins
  always_ff @(posedge clk) begin
    if (rst) begin
      op_q  <= '0;
      imm_q <= '0;
    end else if (conf_valid && conf_word.sel == $bits(conf_word.sel)'(pe_index)) begin
      op_q  <= conf_word.opcode;
      imm_q <= conf_word.imm;
    end
  end

  always_comb begin
    case (op_q)
      cgra_pkg::OP_ADD:  alu = op_data + imm_q;
      cgra_pkg::OP_SUB:  alu = op_data - imm_q;
      cgra_pkg::OP_XOR:  alu = op_data ^ imm_q;
      cgra_pkg::OP_MUL:  alu = op_data * imm_q;   // Low half only
      cgra_pkg::OP_PASS: alu = op_data;
      default:           alu = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= op_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid) begin
      lane_data <= in_en ? alu : '0;           // Disabled lane gives zero
    end
  end

endmodule

/* logic/cgra_pkg.sv */
package cgra_pkg;

  // ******************************
  // Array and bus sizes
  // ******************************
  localparam int N_PE           = 4;
  localparam int LINE_W         = 512;
  localparam int CONF_W         = 64;
  localparam int WORDS_PER_LINE = LINE_W / CONF_W;
  localparam int DATA_W         = 32;

  // Header line fields
  localparam int HDR_CNT_LSB      = 0;
  localparam int HDR_CNT_W        = 32;
  localparam int HDR_IN_MASK_LSB  = 32;
  localparam int HDR_OUT_MASK_LSB = 64;

  typedef logic [LINE_W-1:0]       line_t;
  typedef logic [DATA_W-1:0]       data_t;
  typedef logic [N_PE*DATA_W-1:0]  result_t;
  typedef logic [N_PE-1:0]         lane_mask_t;

  typedef struct packed {
    logic [DATA_W-1:0]       imm;      // Bits 63:32
    logic [23:0]             rsvd_hi;
    logic [3:0]              opcode;   // Bits 7:4
    logic [1:0]              rsvd_lo;
    logic [$clog2(N_PE)-1:0] sel;      // Target PE
  } conf_word_t;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_XOR  = 4'd2,
    OP_MUL  = 4'd3,
    OP_PASS = 4'd4
  } opcode_e;

endpackage

/* logic/cgra_result_merge.sv */
`timescale 1ns/1ps

module cgra_result_merge (
  input  logic                 clk,
  input  logic                 rst,
  input  cgra_pkg::lane_mask_t lane_valid,
  input  cgra_pkg::data_t      lane_data [cgra_pkg::N_PE],
  input  cgra_pkg::lane_mask_t out_mask,
  input  logic                 res_done,
  output logic                 ready,
  output logic                 res_valid,
  output cgra_pkg::result_t    res_data
);

  logic busy;

  // All lanes fire together, lane 0 stands for the array
  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= 1'b0;
      if (lane_valid[0] && !busy) begin
        busy      <= 1'b1;
        res_valid <= 1'b1;
      end else if (res_done) begin
        busy <= 1'b0;                            // Result port free again
      end
    end
  end

  // ******************************
  // Lane packing with output mask
  // ******************************
  always_ff @(posedge clk) begin
    if (lane_valid[0] && !busy) begin
      for (int i = 0; i < cgra_pkg::N_PE; i++) begin
        res_data[i*cgra_pkg::DATA_W +: cgra_pkg::DATA_W] <= out_mask[i] ? lane_data[i] : '0;
      end
    end
  end

  assign ready = !busy;

endmodule

/* logic/hs_slice.sv */
`timescale 1ns/1ps

module hs_slice #(
  parameter type payload_t = logic,
  parameter bit  is_sender = 1'b0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_req,
  input  payload_t in_data,
  output logic     in_ack,
  input  logic     enable,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     in_valid,
  output logic     out_req,
  input  logic     out_ack
);

  logic cap;

  // Payload register shared by both variants
  always_ff @(posedge clk) begin
    if (cap) begin
      out_data <= in_data;
    end
  end

  generate
    if (is_sender) begin : g_send
      logic wait_low;                              // Req dropped, ack still high

      assign cap    = in_valid && enable && !in_ack;
      assign in_ack = out_req || wait_low;         // Busy level

      always_ff @(posedge clk) begin
        if (rst) begin
          out_req   <= 1'b0;
          wait_low  <= 1'b0;
          out_valid <= 1'b0;
        end else begin
          out_valid <= 1'b0;
          if (cap) begin
            out_req <= 1'b1;
          end else if (out_req && out_ack) begin
            out_req  <= 1'b0;
            wait_low <= 1'b1;
          end else if (wait_low && !out_ack) begin
            wait_low  <= 1'b0;
            out_valid <= 1'b1;                     // Handshake complete
          end
        end
      end
    end else begin : g_recv
      assign cap     = in_req && !in_ack && enable;
      assign out_req = 1'b0;

      always_ff @(posedge clk) begin
        if (rst) begin
          in_ack    <= 1'b0;
          out_valid <= 1'b0;
        end else begin
          out_valid <= cap;
          if (cap) begin
            in_ack <= 1'b1;
          end else if (!in_req) begin
            in_ack <= 1'b0;                        // Return phase
          end
        end
      end
    end
  endgenerate

endmodule

/* tests/cgra_conf_props.sv */
`timescale 1ns/1ps

module cgra_conf_props (
  input logic              clk,
  input logic              rst,
  input logic              done,
  input logic              line_req,
  input logic              line_ack,
  input cgra_pkg::line_t   line_data,
  input logic              op_req,
  input logic              op_ack,
  input logic              res_req,
  input logic              res_ack,
  input cgra_pkg::result_t res_data
);

  // ******************************
  // Four-phase req holding
  // ******************************
  a_line_req_hold: assert property (@(posedge clk) disable iff (rst)
    line_req && !line_ack |=> line_req)
    else $error("line_req fell before line_ack rose");

  a_op_req_hold: assert property (@(posedge clk) disable iff (rst)
    op_req && !op_ack |=> op_req)
    else $error("op_req fell before op_ack rose");

  a_res_req_hold: assert property (@(posedge clk) disable iff (rst)
    res_req && !res_ack |=> res_req)
    else $error("res_req fell before res_ack rose");

  // ******************************
  // Payload stability
  // ******************************
  // Line source holds its data from ack until the controller drops req
  a_line_data_stable: assert property (@(posedge clk) disable iff (rst)
    line_req && line_ack |=> $stable(line_data))
    else $error("line_data changed during the line handshake");

  a_res_data_stable: assert property (@(posedge clk) disable iff (rst)
    res_req && !res_ack |=> $stable(res_data))
    else $error("res_data changed while res_req was high");

  a_op_ack_after_done: assert property (@(posedge clk) disable iff (rst)
    op_ack |-> done)
    else $error("op_ack rose before configuration was done");

endmodule

bind cgra_conf_top cgra_conf_props u_props (
  .clk       (clk),
  .rst       (rst),
  .done      (done),
  .line_req  (line_req),
  .line_ack  (line_ack),
  .line_data (line_data),
  .op_req    (op_req),
  .op_ack    (op_ack),
  .res_req   (res_req),
  .res_ack   (res_ack),
  .res_data  (res_data)
);

/* tests/cgra_conf_tb.sv */
`timescale 1ns/1ps

module cgra_conf_tb;

  localparam int TIMEOUT    = 300;             // Cycles per wait
  localparam int W_LINE_REQ = 0;
  localparam int W_OP_ACK   = 1;
  localparam int W_RES_REQ  = 2;
  localparam int W_FETCH    = 3;               // line_req or done
  localparam int W_DONE     = 4;

  logic              clk;
  logic              rst;
  logic              start;
  logic              done;
  logic              line_req;
  logic              line_ack;
  cgra_pkg::line_t   line_data;
  logic              op_req;
  cgra_pkg::data_t   op_data;
  logic              op_ack;
  logic              res_req;
  cgra_pkg::result_t res_data;
  logic              res_ack;

  cgra_pkg::line_t   lines [$];
  cgra_pkg::data_t   ops [$];
  cgra_pkg::result_t exps [$];
  bit                early [$];              // Offered before done
  string             test_name;
  logic [31:0]       word_cnt;
  int                fd;
  int                checks;
  int                errors;
  int                test_errors;
  int                tests_run;
  int                tests_failed;

  cgra_conf_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .done      (done),
    .line_req  (line_req),
    .line_ack  (line_ack),
    .line_data (line_data),
    .op_req    (op_req),
    .op_data   (op_data),
    .op_ack    (op_ack),
    .res_req   (res_req),
    .res_data  (res_data),
    .res_ack   (res_ack)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $finish;
  endtask

  // ******************************
  // Compare tasks
  // ******************************
  task automatic check_result(input string what, input cgra_pkg::result_t exp,
                              input cgra_pkg::result_t act);
    checks++;
    if (act !== exp) begin
      test_errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_done(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      test_errors++;
      $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    checks++;
    if (act != exp) begin
      test_errors++;
      $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  function automatic logic probe(input int sel);
    case (sel)
      W_LINE_REQ: return line_req;
      W_OP_ACK:   return op_ack;
      W_RES_REQ:  return res_req;
      W_FETCH:    return line_req || done;
      default:    return done;
    endcase
  endfunction

  task automatic wait_level(input int sel, input logic level, input string what);
    int n;
    n = 0;
    while (probe(sel) !== level && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (probe(sel) !== level) begin
      abort_run($sformatf("In test %s, %s did not go %s within %0d cycles",
                          test_name, what, level ? "high" : "low", TIMEOUT));
    end
  endtask

  // ******************************
  // Line source, operand driver, result sink
  // ******************************
  task automatic feed_lines();
    int n;
    int delay;
    n = 0;
    wait_level(W_FETCH, 1'b1, "line_req or done");
    while (!done) begin
      delay = $urandom % 6;
      repeat (delay) @(posedge clk);
      line_data <= (n < lines.size()) ? lines[n] : '0;
      line_ack  <= 1'b1;
      n++;
      wait_level(W_LINE_REQ, 1'b0, "line_req");
      line_ack <= 1'b0;
      wait_level(W_FETCH, 1'b1, "line_req or done");
    end
    check_count("line fetches", 1 + int'((word_cnt + 7) / 8), n);
    check_done("line_req at done", 1'b0, line_req);
  endtask

  task automatic drive_operands();
    for (int i = 0; i < ops.size(); i++) begin
      if (!early[i]) begin
        wait_level(W_DONE, 1'b1, "done");
      end
      op_data <= ops[i];
      op_req  <= 1'b1;
      wait_level(W_OP_ACK, 1'b1, "op_ack");
      check_done("done at op_ack", 1'b1, done);
      op_req <= 1'b0;
      wait_level(W_OP_ACK, 1'b0, "op_ack");
    end
  endtask

  task automatic collect_results();
    int delay;
    for (int i = 0; i < exps.size(); i++) begin
      wait_level(W_RES_REQ, 1'b1, "res_req");
      delay = $urandom % 6;                  // Back-pressure
      repeat (delay) @(posedge clk);
      check_result($sformatf("result %0d", i), exps[i], res_data);
      res_ack <= 1'b1;
      wait_level(W_RES_REQ, 1'b0, "res_req");
      res_ack <= 1'b0;
    end
  endtask

  task automatic run_session();
    test_errors = 0;
    rst      <= 1'b1;
    start    <= 1'b0;
    line_ack <= 1'b0;
    op_req   <= 1'b0;
    res_ack  <= 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_done("done after reset", 1'b0, done);
    check_done("line_req after reset", 1'b0, line_req);
    check_done("res_req after reset", 1'b0, res_req);
    check_done("op_ack after reset", 1'b0, op_ack);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    fork
      feed_lines();
      drive_operands();
      collect_results();
    join
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
      $display("[PASS] %s", test_name);
    end else begin
      tests_failed++;
      $display("[FAIL] %s, %0d errors", test_name, test_errors);
    end
  endtask

  // Skips comment lines and gives 0 at end of file
  task automatic read_tag(output byte tag);
    int c;
    tag = "#";
    while (tag == "#") begin
      if ($fscanf(fd, " %c", tag) != 1) begin
        tag = 0;
      end else if (tag == "#") begin
        c = $fgetc(fd);
        while (c != "\n" && c != -1) begin
          c = $fgetc(fd);
        end
      end
    end
  endtask

  // ******************************
  // Trace reader
  // ******************************
  initial begin
    byte               tag;
    int                seed;
    logic [15:0]       in_m;
    logic [15:0]       out_m;
    logic [63:0]       word;
    cgra_pkg::line_t   cur;
    cgra_pkg::data_t   op;
    cgra_pkg::result_t exp;
    clk       = 1'b0;
    rst       = 1'b1;
    start     = 1'b0;
    line_ack  = 1'b0;
    line_data = '0;
    op_req    = 1'b0;
    op_data   = '0;
    res_ack   = 1'b0;
    seed      = 24378;
    void'($urandom(seed));
    fd = $fopen("tests/cgra_conf_trace.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open tests/cgra_conf_trace.txt");
    end else begin
      read_tag(tag);
      while (tag == "S") begin
        void'($fscanf(fd, "%s %h %h %h", test_name, word_cnt, in_m, out_m));
        lines.delete();
        ops.delete();
        exps.delete();
        early.delete();
        cur = '0;
        cur[31:0]  = word_cnt;               // Header line
        cur[47:32] = in_m;
        cur[79:64] = out_m;
        lines.push_back(cur);
        cur = '0;
        for (int i = 0; i < word_cnt; i++) begin
          void'($fscanf(fd, "%h", word));
          cur[(i % 8) * 64 +: 64] = word;    // Least significant first
          if (i % 8 == 7 || i == word_cnt - 1) begin
            lines.push_back(cur);
            cur = '0;
          end
        end
        read_tag(tag);
        while (tag == "O" || tag == "P") begin
          void'($fscanf(fd, "%h %h", op, exp));
          ops.push_back(op);
          exps.push_back(exp);
          early.push_back(tag == "P");
          read_tag(tag);
        end
        run_session();
        read_tag(tag);
      end
      $fclose(fd);
      $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0 && tests_run > 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

/* tests/cgra_conf_trace.txt */
# S name word_count in_mask out_mask, then the words (imm 63:32, opcode 7:4, PE 1:0)
# O operand result (lane 3 first), P operand offered before done, E ends the test
S opcodes 4 f f
0000001000000000 0000000300000011 ff00ff0000000022 0000000700000033
O 00000005 00000023ff00ff050000000200000015
O 80000001 800000077f00ff017ffffffe80000011
O 00000000 00000000ff00ff00fffffffd00000010
E
S two_lines 9 f f
0000000100000000 0000000200000001 0000000300000002 0000000400000003
0000000100000010 0000000f00000021 0000000300000032 0000000000000043
aaaaaaaa00000020
O 00000055 00000055000000ff0000005aaaaaaaff
O 12345678 12345678369d036812345677b89efcd2
E
S masks 4 fffb fffe
0000000100000000 0000000100000001 0000000100000002 0000000100000003
O 00000100 00000101000000000000010100000000
E
S pass_invalid_early 3 f f
1234567800000040 00000005000000f1 0000001000000013
P 00000050 00000040000000500000000000000050
O 00000007 fffffff7000000070000000000000007
E
S empty 0 f f
O 00000011 00000011000000110000001100000011
E
